//--- files.f
+incdir+src
src/icache_pkg.sv
src/icache_ram.sv
src/fetch_decode.sv
src/tag_lookup.sv
src/refill_ctrl.sv
src/fetch_result.sv
src/icache_top.sv
verif/icache_tb.sv

//--- verif/icache_tb.sv
// instruction cache testbench
`timescale 1ns/10ps

module icache_tb;
  import icache_pkg::*;

  localparam int TIMEOUT = 100;

  logic   clk;
  logic   rst_n;
  logic   req_valid_i;
  addr_t  req_addr_i;
  logic   req_inv_i;
  logic   req_ready_o;
  logic   rsp_valid_o;
  word_t  rsp_instr_o;
  addr_t  rsp_addr_o;
  logic   rsp_excp_o;
  logic   rsp_ready_i;
  logic   ar_valid_o;
  addr_t  ar_addr_o;
  logic   ar_ready_i;
  logic   r_valid_i;
  word_t  r_data_i;
  logic   r_last_i;
  logic   r_ready_o;

  int     errors;
  int     timeouts;
  int     ar_count;
  addr_t  last_ar_addr;
  integer seed = 26508;

  icache_top icache_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_inv_i   (req_inv_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_instr_o (rsp_instr_o),
    .rsp_addr_o  (rsp_addr_o),
    .rsp_excp_o  (rsp_excp_o),
    .rsp_ready_i (rsp_ready_i),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .r_last_i    (r_last_i),
    .r_ready_o   (r_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // burst memory model
  // ====================
  // each word reads back as the inverse of its byte address
  initial begin : mem_model
    addr_t line_addr;
    int    delay;
    forever begin
      @(posedge clk);
      #2;
      if (rst_n && ar_valid_o) begin
        line_addr    = ar_addr_o;
        last_ar_addr = ar_addr_o;
        delay        = {$random(seed)} % 4;
        for (int d = 0; d < delay; d++) begin
          @(posedge clk);
          #2;
        end
        ar_ready_i = 1'b1;
        @(posedge clk);
        #2;
        ar_ready_i = 1'b0;
        ar_count++;
        for (int b = 0; b < 4; b++) begin
          if (!r_ready_o) report_mismatch("r_ready_o", r_ready_o, 1);
          r_valid_i = 1'b1;
          r_data_i  = ~(line_addr + addr_t'(4 * b));
          r_last_i  = (b == 3);
          @(posedge clk);
          #2;
        end
        r_valid_i = 1'b0;
        r_last_i  = 1'b0;
      end
    end
  end

  // ====================
  // helpers
  // ====================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  // called and returns 2 ns after a rising edge
  task automatic send_req(input addr_t a, input logic inv);
    int t;
    t           = 0;
    req_valid_i = 1'b1;
    req_addr_i  = a;
    req_inv_i   = inv;
    @(negedge clk);
    while (!req_ready_o && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!req_ready_o) begin
      $display("request for %h was never accepted", a);
      timeouts++;
    end
    @(posedge clk);
    #2;
    req_valid_i = 1'b0;
    req_inv_i   = 1'b0;
  endtask

  task automatic wait_rsp(input addr_t a, input logic at_once);
    int    t;
    logic  exp_excp;
    word_t exp_instr;
    t         = 0;
    exp_excp  = (a[1:0] != 2'b00);
    exp_instr = exp_excp ? '0 : ~a;
    @(negedge clk);
    while (!rsp_valid_o && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!rsp_valid_o) begin
      $display("no response for address %h", a);
      timeouts++;
    end else begin
      if (at_once && t != 0) report_mismatch("response latency", t, 0);
      if (rsp_addr_o !== a) report_mismatch("rsp_addr_o", rsp_addr_o, a);
      if (rsp_instr_o !== exp_instr) report_mismatch("rsp_instr_o", rsp_instr_o, exp_instr);
      if (rsp_excp_o !== exp_excp) report_mismatch("rsp_excp_o", rsp_excp_o, exp_excp);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic fetch_check(input addr_t a, input int exp_reads);
    int    n0;
    addr_t line_a;
    n0     = ar_count;
    line_a = {a[31:4], 4'h0};
    send_req(a, 1'b0);
    wait_rsp(a, exp_reads == 0);
    if (ar_count - n0 != exp_reads) report_mismatch("read requests", ar_count - n0, exp_reads);
    if (exp_reads == 1 && last_ar_addr !== line_a) begin
      report_mismatch("ar_addr_o", last_ar_addr, line_a);
    end
  endtask

  // ====================
  // directed tests
  // ====================
  task automatic cold_fetch();
    fetch_check(32'h0000_1048, 1);
  endtask

  // four hits back to back with one response per cycle
  task automatic line_hit_burst();
    int    n0;
    addr_t a;
    n0 = ar_count;
    for (int i = 0; i < 5; i++) begin
      req_valid_i = (i < 4);
      req_addr_i  = 32'h0000_1040 + 4 * i;
      @(negedge clk);
      if (i < 4 && !req_ready_o) report_mismatch("req_ready_o", req_ready_o, 1);
      if (i > 0) begin
        a = 32'h0000_1040 + 4 * (i - 1);
        if (!rsp_valid_o) report_mismatch("rsp_valid_o", rsp_valid_o, 1);
        if (rsp_addr_o !== a) report_mismatch("rsp_addr_o", rsp_addr_o, a);
        if (rsp_instr_o !== ~a) report_mismatch("rsp_instr_o", rsp_instr_o, ~a);
      end
      @(posedge clk);
      #2;
    end
    req_valid_i = 1'b0;
    if (ar_count != n0) report_mismatch("read requests", ar_count - n0, 0);
  endtask

  task automatic misaligned_fetch();
    fetch_check(32'h0000_3002, 0);
    repeat (3) begin
      @(negedge clk);
      if (ar_valid_o) report_mismatch("ar_valid_o", ar_valid_o, 0);
    end
    @(posedge clk);
    #2;
  endtask

  // tags 1, 2 and 3 in set 5
  task automatic way_replacement();
    fetch_check(32'h0001_0050, 1);
    fetch_check(32'h0002_0054, 1);
    fetch_check(32'h0001_0058, 0);
    fetch_check(32'h0002_005C, 0);
    fetch_check(32'h0003_0050, 1);
    fetch_check(32'h0001_0050, 1);
  endtask

  // set 5 holds tags 3 and 1, one in each way
  task automatic set_invalidate();
    send_req(32'h0001_0050, 1'b1);
    @(negedge clk);
    if (rsp_valid_o) report_mismatch("rsp_valid_o", rsp_valid_o, 0);
    @(posedge clk);
    #2;
    fetch_check(32'h0001_0054, 1);
    fetch_check(32'h0003_0058, 1);
  endtask

  task automatic rsp_backpressure();
    word_t held_instr;
    rsp_ready_i = 1'b0;
    send_req(32'h0000_104C, 1'b0);
    // second request waits behind the stalled one
    req_valid_i = 1'b1;
    req_addr_i  = 32'h0000_1040;
    @(negedge clk);
    if (!rsp_valid_o) report_mismatch("rsp_valid_o", rsp_valid_o, 1);
    held_instr = rsp_instr_o;
    if (held_instr !== ~32'h0000_104C) report_mismatch("rsp_instr_o", held_instr, ~32'h0000_104C);
    repeat (4) begin
      @(negedge clk);
      if (!rsp_valid_o) report_mismatch("rsp_valid_o", rsp_valid_o, 1);
      if (rsp_instr_o !== held_instr) report_mismatch("rsp_instr_o", rsp_instr_o, held_instr);
      if (rsp_addr_o !== 32'h0000_104C) report_mismatch("rsp_addr_o", rsp_addr_o, 32'h104C);
      if (req_ready_o) report_mismatch("req_ready_o", req_ready_o, 0);
    end
    @(posedge clk);
    #2;
    rsp_ready_i = 1'b1;
    @(negedge clk);
    if (!rsp_valid_o) report_mismatch("rsp_valid_o", rsp_valid_o, 1);
    if (!req_ready_o) report_mismatch("req_ready_o", req_ready_o, 1);
    @(posedge clk);
    #2;
    req_valid_i = 1'b0;
    wait_rsp(32'h0000_1040, 1'b1);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_inv_i    = 1'b0;
    rsp_ready_i  = 1'b1;
    ar_ready_i   = 1'b0;
    r_valid_i    = 1'b0;
    r_data_i     = '0;
    r_last_i     = 1'b0;
    errors       = 0;
    timeouts     = 0;
    ar_count     = 0;
    last_ar_addr = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (!req_ready_o) report_mismatch("req_ready_o", req_ready_o, 1);
    if (rsp_valid_o) report_mismatch("rsp_valid_o", rsp_valid_o, 0);
    if (ar_valid_o) report_mismatch("ar_valid_o", ar_valid_o, 0);
    if (r_ready_o) report_mismatch("r_ready_o", r_ready_o, 0);
    @(posedge clk);
    #2;
    cold_fetch();
    line_hit_burst();
    misaligned_fetch();
    way_replacement();
    set_invalidate();
    rsp_backpressure();
    $display("value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src/icache_top.sv
// two-way instruction cache
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  icache_pkg::addr_t req_addr_i,
  input  logic              req_inv_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output icache_pkg::word_t rsp_instr_o,
  output icache_pkg::addr_t rsp_addr_o,
  output logic              rsp_excp_o,
  input  logic              rsp_ready_i,
  output logic              ar_valid_o,
  output icache_pkg::addr_t ar_addr_o,
  input  logic              ar_ready_i,
  input  logic              r_valid_i,
  input  icache_pkg::word_t r_data_i,
  input  logic              r_last_i,
  output logic              r_ready_o
);
  import icache_pkg::*;

  logic                    s1_valid;
  logic                    s1_inv;
  logic                    s1_adef;
  logic                    s1_advance;
  addr_t                   s1_addr;
  idx_t                    rd_idx;
  idx_t                    s1_idx;
  tag_t                    s1_tag;
  logic                    hit;
  way_t                    hit_way;
  logic [`ICACHE_WAYS-1:0] tag_we;
  logic [`ICACHE_WAYS-1:0] line_we;
  logic                    refill_done;
  logic                    refill_busy;
  line_t                   refill_line;
  tag_t                    tag_rd [`ICACHE_WAYS];
  line_t                   line_rd [`ICACHE_WAYS];

  // refills always target the stage-1 set
  assign s1_idx = s1_addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s1_tag = s1_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // ====================
  // pipeline
  // ====================
  fetch_decode fetch_decode_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_inv_i    (req_inv_i),
    .s1_advance_i (s1_advance),
    .req_ready_o  (req_ready_o),
    .s1_valid_o   (s1_valid),
    .s1_inv_o     (s1_inv),
    .s1_adef_o    (s1_adef),
    .s1_addr_o    (s1_addr),
    .rd_idx_o     (rd_idx)
  );

  tag_lookup tag_lookup_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .s1_valid_i    (s1_valid),
    .s1_inv_i      (s1_inv),
    .s1_adef_i     (s1_adef),
    .s1_addr_i     (s1_addr),
    .tag_rd0_i     (tag_rd[0]),
    .tag_rd1_i     (tag_rd[1]),
    .refill_done_i (refill_done),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .tag_we_o      (tag_we),
    .line_we_o     (line_we)
  );

  refill_ctrl refill_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .s1_valid_i    (s1_valid),
    .s1_inv_i      (s1_inv),
    .s1_adef_i     (s1_adef),
    .hit_i         (hit),
    .s1_addr_i     (s1_addr),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i),
    .r_last_i      (r_last_i),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .r_ready_o     (r_ready_o),
    .refill_busy_o (refill_busy),
    .refill_done_o (refill_done),
    .refill_line_o (refill_line)
  );

  fetch_result fetch_result_inst (
    .s1_valid_i    (s1_valid),
    .s1_inv_i      (s1_inv),
    .s1_adef_i     (s1_adef),
    .s1_addr_i     (s1_addr),
    .hit_i         (hit),
    .hit_way_i     (hit_way),
    .line_rd0_i    (line_rd[0]),
    .line_rd1_i    (line_rd[1]),
    .refill_busy_i (refill_busy),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_instr_o   (rsp_instr_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_excp_o    (rsp_excp_o),
    .s1_advance_o  (s1_advance)
  );

  // ====================
  // tag and line memories
  // ====================
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_ram #(
      .payload_t (tag_t)
    ) tag_ram_inst (
      .clk     (clk),
      .we_i    (tag_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (s1_tag),
      .raddr_i (rd_idx),
      .rdata_o (tag_rd[w])
    );

    icache_ram #(
      .payload_t (line_t)
    ) line_ram_inst (
      .clk     (clk),
      .we_i    (line_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (refill_line),
      .raddr_i (rd_idx),
      .rdata_o (line_rd[w])
    );
  end

endmodule

//--- src/fetch_result.sv
// fetch response stage
`timescale 1ns/10ps
`include "icache_defines.svh"

module fetch_result (
  input  logic              s1_valid_i,
  input  logic              s1_inv_i,
  input  logic              s1_adef_i,
  input  icache_pkg::addr_t s1_addr_i,
  input  logic              hit_i,
  input  icache_pkg::way_t  hit_way_i,
  input  icache_pkg::line_t line_rd0_i,
  input  icache_pkg::line_t line_rd1_i,
  input  logic              refill_busy_i,
  input  logic              rsp_ready_i,
  output logic              rsp_valid_o,
  output icache_pkg::word_t rsp_instr_o,
  output icache_pkg::addr_t rsp_addr_o,
  output logic              rsp_excp_o,
  output logic              s1_advance_o
);
  import icache_pkg::*;

  line_t hit_line;
  word_t hit_word;

  // word select within the hit line
  assign hit_line = hit_way_i ? line_rd1_i : line_rd0_i;
  assign hit_word = hit_line[s1_addr_i[`ICACHE_OFS_W-1:2]];

  // ====================
  // response
  // ====================
  assign rsp_valid_o = s1_valid_i & ~s1_inv_i & (hit_i | s1_adef_i);
  assign rsp_excp_o  = s1_valid_i & s1_adef_i;
  assign rsp_instr_o = s1_adef_i ? '0 : hit_word;
  assign rsp_addr_o  = s1_addr_i;

  // invalidates retire without a response
  assign s1_advance_o = ~refill_busy_i &
                        (~s1_valid_i | s1_inv_i | (rsp_valid_o & rsp_ready_i));

endmodule

//--- src/refill_ctrl.sv
// line refill over the read burst port
`timescale 1ns/10ps
`include "icache_defines.svh"

module refill_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              s1_valid_i,
  input  logic              s1_inv_i,
  input  logic              s1_adef_i,
  input  logic              hit_i,
  input  icache_pkg::addr_t s1_addr_i,
  input  logic              ar_ready_i,
  input  logic              r_valid_i,
  input  icache_pkg::word_t r_data_i,
  input  logic              r_last_i,
  output logic              ar_valid_o,
  output icache_pkg::addr_t ar_addr_o,
  output logic              r_ready_o,
  output logic              refill_busy_o,
  output logic              refill_done_o,
  output icache_pkg::line_t refill_line_o
);
  import icache_pkg::*;

  refill_state_t                         state_q;
  logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_q;
  logic                                  miss_seen;
  logic                                  beat_take;

  // all beats except the last one
  word_t beat_buf [`ICACHE_LINE_WORDS-1];

  assign miss_seen = s1_valid_i & ~s1_inv_i & ~s1_adef_i & ~hit_i;
  assign beat_take = (state_q == RF_REFILL) & r_valid_i;

  // ====================
  // FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RF_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        RF_IDLE:   if (miss_seen) state_q <= RF_MISS;
        RF_MISS:   if (ar_ready_i) state_q <= RF_REFILL;
        RF_REFILL: if (r_valid_i && r_last_i) state_q <= RF_IDLE;
        default:   state_q <= RF_IDLE;
      endcase
      if (state_q != RF_REFILL) begin
        beat_q <= '0;
      end else if (r_valid_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_take && !r_last_i) begin
      beat_buf[beat_q] <= r_data_i;
    end
  end

  // last beat goes straight into the RAM write
  always_comb begin
    for (int w = 0; w < `ICACHE_LINE_WORDS - 1; w++) begin
      refill_line_o[w] = beat_buf[w];
    end
    refill_line_o[`ICACHE_LINE_WORDS-1] = r_data_i;
  end

  assign ar_valid_o    = (state_q == RF_MISS);
  assign ar_addr_o     = {s1_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
  assign r_ready_o     = (state_q == RF_REFILL);
  assign refill_busy_o = (state_q != RF_IDLE);
  assign refill_done_o = beat_take & r_last_i;

  a_ar_hold : assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

endmodule

//--- src/tag_lookup.sv
// tag match and line state
`timescale 1ns/10ps
`include "icache_defines.svh"

module tag_lookup (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s1_valid_i,
  input  logic                    s1_inv_i,
  input  logic                    s1_adef_i,
  input  icache_pkg::addr_t       s1_addr_i,
  input  icache_pkg::tag_t        tag_rd0_i,
  input  icache_pkg::tag_t        tag_rd1_i,
  input  logic                    refill_done_i,
  output logic                    hit_o,
  output icache_pkg::way_t        hit_way_o,
  output logic [`ICACHE_WAYS-1:0] tag_we_o,
  output logic [`ICACHE_WAYS-1:0] line_we_o
);
  import icache_pkg::*;

  idx_t                    s1_idx;
  tag_t                    s1_tag;
  way_t                    victim;
  logic                    lookup;
  logic [`ICACHE_WAYS-1:0] way_hit;
  logic [`ICACHE_WAYS-1:0] fill_we;

  // per-set line state
  logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
  logic [`ICACHE_SETS-1:0]                   repl_q;

  assign s1_idx = s1_addr_i[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s1_tag = s1_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // ====================
  // match
  // ====================
  assign lookup     = s1_valid_i & ~s1_inv_i & ~s1_adef_i;
  assign way_hit[0] = valid_q[s1_idx][0] & (tag_rd0_i == s1_tag);
  assign way_hit[1] = valid_q[s1_idx][1] & (tag_rd1_i == s1_tag);
  assign hit_o      = lookup & (|way_hit);
  assign hit_way_o  = way_hit[1];

  // repl bit names the next way to replace
  assign victim = repl_q[s1_idx];

  always_comb begin
    fill_we = '0;
    if (refill_done_i) begin
      fill_we[victim] = 1'b1;
    end
  end

  assign tag_we_o  = fill_we;
  assign line_we_o = fill_we;

  // ====================
  // valid and replacement
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      repl_q  <= '0;
    end else begin
      if (s1_valid_i && s1_inv_i) begin
        valid_q[s1_idx] <= '0;
      end else if (refill_done_i) begin
        valid_q[s1_idx][victim] <= 1'b1;
      end
      // hit on the victim moves the pointer to the other way
      if (hit_o) begin
        repl_q[s1_idx] <= ~hit_way_o;
      end
    end
  end

  a_one_way : assert property (@(posedge clk) disable iff (!rst_n)
    lookup |-> $onehot0(way_hit));

endmodule

//--- src/fetch_decode.sv
// fetch request decode stage
`timescale 1ns/10ps
`include "icache_defines.svh"

module fetch_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  icache_pkg::addr_t req_addr_i,
  input  logic              req_inv_i,
  input  logic              s1_advance_i,
  output logic              req_ready_o,
  output logic              s1_valid_o,
  output logic              s1_inv_o,
  output logic              s1_adef_o,
  output icache_pkg::addr_t s1_addr_o,
  output icache_pkg::idx_t  rd_idx_o
);
  import icache_pkg::*;

  logic accept;
  logic adef;
  idx_t req_idx;
  idx_t s1_idx;

  assign req_ready_o = s1_advance_i;
  assign accept      = req_valid_i & s1_advance_i;

  // invalidates never raise the misaligned flag
  assign adef = ~req_inv_i & (req_addr_i[1:0] != 2'b00);

  // ====================
  // stage 1 register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_o <= 1'b0;
      s1_inv_o   <= 1'b0;
      s1_adef_o  <= 1'b0;
    end else if (s1_advance_i) begin
      s1_valid_o <= accept;
      s1_inv_o   <= accept & req_inv_i;
      s1_adef_o  <= accept & adef;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_addr_o <= req_addr_i;
    end
  end

  // re-read the held set while stage 1 stalls
  assign req_idx  = req_addr_i[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s1_idx   = s1_addr_o[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign rd_idx_o = s1_advance_i ? req_idx : s1_idx;

  // only an occupied stage 1 can stall
  a_s1_hold : assert property (@(posedge clk) disable iff (!rst_n)
    !s1_advance_i |-> s1_valid_o);

endmodule

//--- src/icache_ram.sv
// set-indexed cache memory
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ram #(
  parameter type payload_t = logic [31:0]
) (
  input  logic             clk,
  input  logic             we_i,
  input  icache_pkg::idx_t waddr_i,
  input  payload_t         wdata_i,
  input  icache_pkg::idx_t raddr_i,
  output payload_t         rdata_o
);

  // one entry per set
  payload_t mem_q [`ICACHE_SETS];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // ====================
  // read port
  // ====================
  // write-first so a same-set write is read back at once
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

//--- src/icache_pkg.sv
// instruction cache types
`include "icache_defines.svh"

package icache_pkg;

  // untranslated fetch address
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // one instruction
  typedef logic [31:0] word_t;

  // full cache line with word 0 in the low bits
  typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_IDX_W-1:0] idx_t;
  typedef logic way_t;

  // refill controller
  typedef enum logic [1:0] {
    RF_IDLE   = 2'd0,
    RF_MISS   = 2'd1,
    RF_REFILL = 2'd2
  } refill_state_t;

endpackage

//--- src/icache_defines.svh
// instruction cache geometry
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ====================
// address
// ====================
`define ICACHE_ADDR_W 32

// ====================
// organisation
// ====================
`define ICACHE_WAYS 2
`define ICACHE_SETS 16
// 32-bit words per line
`define ICACHE_LINE_WORDS 4

// ====================
// address split
// ====================
// byte offset within a line
`define ICACHE_OFS_W 4
`define ICACHE_IDX_W 4
// remaining upper address bits
`define ICACHE_TAG_W 24

`endif
